/* hw/bootRom.sv */
`timescale 1ns/1ns

module bootRom import configure::*; (
  input logic clock,
  input logic reset,
  input memInType romIn,
  output memOutType romOut
);

  logic [5:0] wordIndex;
  logic [31:0] romData;
  logic ready;

  assign wordIndex = romIn.memAddr[7:2];

  // --------------------------------------------------------------------------
  // Boot image, words 40 and up read zero

  always_ff @(posedge clock) begin
    case (wordIndex)
      6'd0: romData <= 32'h41014081;
      6'd1: romData <= 32'h42014181;
      6'd2: romData <= 32'h43014281;
      6'd3: romData <= 32'h44014381;
      6'd4: romData <= 32'h45014481;
      6'd5: romData <= 32'h46014581;
      6'd6: romData <= 32'h47014681;
      6'd7: romData <= 32'h48014781;
      6'd8: romData <= 32'h49014881;
      6'd9: romData <= 32'h4A014981;
      6'd10: romData <= 32'h4B014A81;
      6'd11: romData <= 32'h4C014B81;
      6'd12: romData <= 32'h4D014C81;
      6'd13: romData <= 32'h4E014D81;
      6'd14: romData <= 32'h4F014E81;
      6'd15: romData <= 32'h62F94F81;
      6'd16: romData <= 32'h60028293;
      6'd17: romData <= 32'h3002A073;
      6'd18: romData <= 32'hA07342A1;
      6'd19: romData <= 32'h62853002;
      6'd20: romData <= 32'h80028293;
      6'd21: romData <= 32'h3042A073;
      6'd22: romData <= 32'h00000297;  // Trap vector setup
      6'd23: romData <= 32'h02028293;
      6'd24: romData <= 32'h30529073;
      6'd25: romData <= 32'h010002B7;
      6'd26: romData <= 32'h03370291;
      6'd27: romData <= 32'h43818000;
      6'd28: romData <= 32'h00080E37;
      6'd29: romData <= 32'h0001A001;
      6'd30: romData <= 32'h80000F37;
      6'd31: romData <= 32'h2FF30F61;
      6'd32: romData <= 32'h19E33420;
      6'd33: romData <= 32'h8E83FFFF;
      6'd34: romData <= 32'h00230002;
      6'd35: romData <= 32'h030501D3;
      6'd36: romData <= 32'hD4630385;
      6'd37: romData <= 32'h007301C3;
      6'd38: romData <= 32'h00B73020;
      6'd39: romData <= 32'h80678000;  // Jump to RAM
      default: romData <= 32'h00000000;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      ready <= 1'b0;
    end else begin
      ready <= romIn.memValid;
    end
  end

  assign romOut.memReady = ready;
  assign romOut.memError = 1'b0;  // Writes are refused upstream
  assign romOut.memRdata = romData;

endmodule

/* hw/busController.sv */
`timescale 1ns/1ns

module busController import configure::*; (
  input logic clock,
  input logic reset,
  input memInType memIn,
  output memOutType memOut,
  output memInType romIn,
  output memInType ramIn,
  output memInType timerIn,
  input memOutType romOut,
  input memOutType ramOut,
  input memOutType timerOut
);

  busStateType state;
  regionType region;
  regionType regionReg;
  memInType request;
  logic isWrite;
  logic accessing;
  logic errorReady;

  function automatic regionType decode(input logic [31:0] addr);
    regionType result;
    if ((addr - RomBase) < RomSize) begin
      result = RegionRom;
    end else if ((addr - RamBase) < RamSize) begin
      result = RegionRam;
    end else if ((addr - TimerBase) < TimerSize) begin
      result = RegionTimer;
    end else begin
      result = RegionNone;
    end
    return result;
  endfunction

  assign region = decode(memIn.memAddr);
  assign isWrite = memIn.memWstrb != 4'b0000;

  // --------------------------------------------------------------------------
  // Request FSM

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= StateIdle;
      regionReg <= RegionNone;
      errorReady <= 1'b0;
    end else begin
      errorReady <= state == StateError;
      case (state)
        StateIdle: begin
          if (memIn.memValid) begin
            regionReg <= region;
            if (region == RegionNone || (region == RegionRom && isWrite)) begin
              state <= StateError;
            end else begin
              state <= StateAccess;
            end
          end
        end
        default: state <= StateIdle;  // One cycle in access or error
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == StateIdle && memIn.memValid) begin
      request <= memIn;
    end
  end

  assign accessing = state == StateAccess;

  // Only the recorded target sees valid
  always_comb begin
    romIn = request;
    ramIn = request;
    timerIn = request;
    romIn.memValid = accessing && regionReg == RegionRom;
    ramIn.memValid = accessing && regionReg == RegionRam;
    timerIn.memValid = accessing && regionReg == RegionTimer;
  end

  // Response of the recorded target, or the error pulse
  always_comb begin
    if (errorReady) begin
      memOut = '{memReady: 1'b1, memError: 1'b1, memRdata: '0};
    end else begin
      case (regionReg)
        RegionRom: memOut = romOut;
        RegionRam: memOut = ramOut;
        RegionTimer: memOut = timerOut;
        default: memOut = '0;
      endcase
    end
  end

endmodule

/* hw/configure.sv */
package configure;

  // --------------------------------------------------------------------------
  // Address map

  localparam logic [31:0] RomBase = 32'h0000_0000;
  localparam logic [31:0] RomSize = 32'd256;         // 64 words

  localparam logic [31:0] RamBase = 32'h8000_0000;
  localparam int RamDepth = 1024;                     // Words
  localparam int RamAddrWidth = $clog2(RamDepth);
  localparam logic [31:0] RamSize = 32'(RamDepth * 4);

  localparam logic [31:0] TimerBase = 32'h0200_0000;
  localparam logic [31:0] TimerSize = 32'h10;

  // Timer register offsets
  localparam logic [3:0] TimeLowOffset = 4'h0;
  localparam logic [3:0] TimeHighOffset = 4'h4;
  localparam logic [3:0] CompareLowOffset = 4'h8;
  localparam logic [3:0] CompareHighOffset = 4'hC;

  localparam int TimerDivide = 4;                     // Clocks per tick
  localparam int PrescaleWidth = $clog2(TimerDivide);

  // --------------------------------------------------------------------------
  // Bus types

  typedef struct packed {
    logic memValid;
    logic memInstr;        // Fetch
    logic [31:0] memAddr;
    logic [31:0] memWdata;
    logic [3:0] memWstrb;  // Zero for read
  } memInType;

  typedef struct packed {
    logic memReady;
    logic memError;
    logic [31:0] memRdata;
  } memOutType;

  typedef enum logic [1:0] {
    RegionRom,
    RegionRam,
    RegionTimer,
    RegionNone
  } regionType;

  typedef enum logic [1:0] {
    StateIdle,
    StateAccess,
    StateError
  } busStateType;

endpackage

/* hw/dataRam.sv */
`timescale 1ns/1ns

module dataRam import configure::*; (
  input logic clock,
  input logic reset,
  input memInType ramIn,
  output memOutType ramOut
);

  logic [31:0] memory [RamDepth];
  logic [RamAddrWidth-1:0] index;
  logic [31:0] rdata;
  logic ready;

  assign index = ramIn.memAddr[RamAddrWidth+1:2];

  // Byte lanes written by strobe, read returns the old word
  always_ff @(posedge clock) begin
    if (ramIn.memValid) begin
      for (int lane = 0; lane < 4; lane++) begin
        if (ramIn.memWstrb[lane]) begin
          memory[index][8*lane +: 8] <= ramIn.memWdata[8*lane +: 8];
        end
      end
      rdata <= memory[index];
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      ready <= 1'b0;
    end else begin
      ready <= ramIn.memValid;
    end
  end

  assign ramOut.memReady = ready;
  assign ramOut.memError = 1'b0;
  assign ramOut.memRdata = rdata;

endmodule

/* hw/machineTimer.sv */
`timescale 1ns/1ns

module machineTimer import configure::*; (
  input logic clock,
  input logic reset,
  input memInType timerIn,
  output memOutType timerOut,
  output logic timerIrq
);

  logic [PrescaleWidth-1:0] prescale;
  logic tick;
  logic [63:0] timeCount;
  logic [63:0] compareValue;
  logic writeEnable;
  logic [3:0] offset;
  logic [31:0] readData;
  logic [31:0] rdata;
  logic ready;

  assign offset = timerIn.memAddr[3:0];
  assign writeEnable = timerIn.memValid && (timerIn.memWstrb != 4'b0000);
  assign tick = prescale == PrescaleWidth'(TimerDivide - 1);

  always_ff @(posedge clock) begin
    if (reset || tick) begin
      prescale <= '0;
    end else begin
      prescale <= prescale + 1'b1;
    end
  end

  // --------------------------------------------------------------------------
  // Registers, a time write wins over the tick

  always_ff @(posedge clock) begin
    if (reset) begin
      timeCount <= '0;
    end else if (writeEnable && offset == TimeLowOffset) begin
      timeCount[31:0] <= timerIn.memWdata;
    end else if (writeEnable && offset == TimeHighOffset) begin
      timeCount[63:32] <= timerIn.memWdata;
    end else if (tick) begin
      timeCount <= timeCount + 64'd1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      compareValue <= '1;  // No interrupt until programmed
    end else if (writeEnable && offset == CompareLowOffset) begin
      compareValue[31:0] <= timerIn.memWdata;
    end else if (writeEnable && offset == CompareHighOffset) begin
      compareValue[63:32] <= timerIn.memWdata;
    end
  end

  always_comb begin
    case (offset)
      TimeLowOffset: readData = timeCount[31:0];
      TimeHighOffset: readData = timeCount[63:32];
      CompareLowOffset: readData = compareValue[31:0];
      CompareHighOffset: readData = compareValue[63:32];
      default: readData = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    rdata <= readData;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      ready <= 1'b0;
      timerIrq <= 1'b0;
    end else begin
      ready <= timerIn.memValid;
      timerIrq <= timeCount >= compareValue;  // Level, held until compare moves
    end
  end

  assign timerOut.memReady = ready;
  assign timerOut.memError = 1'b0;
  assign timerOut.memRdata = rdata;

endmodule

/* hw/memorySystem.sv */
`timescale 1ns/1ns

module memorySystem import configure::*; (
  input logic clock,
  input logic reset,
  input memInType memIn,
  output memOutType memOut,
  output logic timerIrq
);

  memInType romIn;
  memInType ramIn;
  memInType timerIn;
  memOutType romOut;
  memOutType ramOut;
  memOutType timerOut;

  busController busController_i (
    .clock(clock),
    .reset(reset),
    .memIn(memIn),
    .memOut(memOut),
    .romIn(romIn),
    .ramIn(ramIn),
    .timerIn(timerIn),
    .romOut(romOut),
    .ramOut(ramOut),
    .timerOut(timerOut)
  );

  bootRom bootRom_i (
    .clock(clock),
    .reset(reset),
    .romIn(romIn),
    .romOut(romOut)
  );

  dataRam dataRam_i (
    .clock(clock),
    .reset(reset),
    .ramIn(ramIn),
    .ramOut(ramOut)
  );

  machineTimer machineTimer_i (
    .clock(clock),
    .reset(reset),
    .timerIn(timerIn),
    .timerOut(timerOut),
    .timerIrq(timerIrq)
  );

endmodule

/* run.sh */
#!/bin/bash
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module memorySystemTb -f verilog.f -o simMemorySystem

./obj_dir/simMemorySystem 2>&1 | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
  exit 1
fi
exit 0

/* test/memorySystemTb.sv */
`timescale 1ns/1ns

module memorySystemTb import configure::*; ();

  localparam int ResponseLatency = 2;
  localparam int RequestTimeout = 20;

  localparam logic [31:0] BootImage [40] = '{
    32'h41014081, 32'h42014181, 32'h43014281, 32'h44014381,
    32'h45014481, 32'h46014581, 32'h47014681, 32'h48014781,
    32'h49014881, 32'h4A014981, 32'h4B014A81, 32'h4C014B81,
    32'h4D014C81, 32'h4E014D81, 32'h4F014E81, 32'h62F94F81,
    32'h60028293, 32'h3002A073, 32'hA07342A1, 32'h62853002,
    32'h80028293, 32'h3042A073, 32'h00000297, 32'h02028293,
    32'h30529073, 32'h010002B7, 32'h03370291, 32'h43818000,
    32'h00080E37, 32'h0001A001, 32'h80000F37, 32'h2FF30F61,
    32'h19E33420, 32'h8E83FFFF, 32'h00230002, 32'h030501D3,
    32'hD4630385, 32'h007301C3, 32'h00B73020, 32'h80678000
  };

  logic clock;
  logic reset;
  memInType memIn;
  memOutType memOut;
  logic timerIrq;
  logic [31:0] ramModel [RamDepth];
  logic [31:0] rngState = 32'h407a_d23a;
  int cycleCount = 0;
  int checkCount = 0;
  int errorCount = 0;

  memorySystem memorySystem_i (
    .clock(clock),
    .reset(reset),
    .memIn(memIn),
    .memOut(memOut),
    .timerIrq(timerIrq)
  );

  always #2 clock = ~clock;

  always @(posedge clock) cycleCount <= cycleCount + 1;

  // --------------------------------------------------------------------------
  // Helpers

  function automatic logic [31:0] nextRandom();
    logic [31:0] x;
    x = rngState;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rngState = x;
    return x;
  endfunction

  function automatic logic isMapped(input logic [31:0] addr);
    return (addr >= RomBase && addr < RomBase + RomSize) ||
      (addr >= RamBase && addr < RamBase + 32'(RamDepth * 4)) ||
      (addr >= TimerBase && addr < TimerBase + 32'h10);
  endfunction

  function automatic logic [31:0] mergeLanes(input logic [31:0] old,
      input logic [31:0] wdata, input logic [3:0] strb);
    logic [31:0] merged;
    merged = old;
    for (int lane = 0; lane < 4; lane++) begin
      if (strb[lane]) begin
        merged[8*lane +: 8] = wdata[8*lane +: 8];
      end
    end
    return merged;
  endfunction

  // One request, response expected exactly two cycles later
  task automatic issueRequest(input logic [31:0] addr, input logic [31:0] wdata,
      input logic [3:0] strb, input logic instr, output logic [31:0] rdata,
      output logic error);
    int cycles;
    logic seen;
    cycles = 0;
    seen = 1'b0;
    @(negedge clock);
    memIn = '{memValid: 1'b1, memInstr: instr, memAddr: addr, memWdata: wdata,
      memWstrb: strb};
    while (!seen && cycles < RequestTimeout) begin
      @(negedge clock);
      cycles++;
      memIn.memValid = 1'b0;
      seen = memOut.memReady;
    end
    rdata = memOut.memRdata;
    error = memOut.memError;
    checkCount++;
    if (!seen) begin
      $display("No response to request at %h within %0d cycles", addr, RequestTimeout);
      errorCount++;
    end else if (cycles != ResponseLatency) begin
      $display("Response to request at %h came after %0d cycles", addr, cycles);
      errorCount++;
    end
  endtask

  task automatic reportTest(input string name, input int errorsBefore);
    $display("%s done, %0d errors", name, errorCount - errorsBefore);
  endtask

  // --------------------------------------------------------------------------
  // Tests

  task automatic readRomWords(input int count);
    logic [31:0] r;
    logic [31:0] expected;
    logic [31:0] rdata;
    logic error;
    int index;
    for (int n = 0; n < count; n++) begin
      r = nextRandom();
      index = int'(r[7:2]);
      expected = index < 40 ? BootImage[index] : 32'h0;  // Tail of the ROM is zero
      issueRequest(RomBase + 32'(index * 4), 32'h0, 4'b0000, r[0], rdata, error);
      checkCount++;
      if (rdata !== expected || error !== 1'b0) begin
        $display("Fail memRdata at %h: got %h expected %h, memError %h",
          RomBase + 32'(index * 4), rdata, expected, error);
        errorCount++;
      end
    end
  endtask

  task automatic fillRam();
    logic [31:0] addr;
    logic [31:0] value;
    logic [31:0] rdata;
    logic error;
    for (int index = 0; index < RamDepth; index++) begin
      addr = RamBase + 32'(index * 4);
      value = (addr * 32'h9E37_79B9) ^ 32'h5A5A_A5A5;
      issueRequest(addr, value, 4'b1111, 1'b0, rdata, error);
      ramModel[index] = value;
    end
  endtask

  task automatic accessRam(input int count, input logic allowWrites);
    logic [31:0] r;
    logic [31:0] wdata;
    logic [3:0] strb;
    logic [31:0] rdata;
    logic error;
    int index;
    for (int n = 0; n < count; n++) begin
      r = nextRandom();
      wdata = nextRandom();
      index = int'(r % RamDepth);
      strb = (allowWrites && r[31]) ? r[15:12] : 4'b0000;
      issueRequest(RamBase + 32'(index * 4), wdata, strb, 1'b0, rdata, error);
      checkCount++;
      if (rdata !== ramModel[index] || error !== 1'b0) begin  // Old word comes back
        $display("Fail memRdata at %h: got %h expected %h, memError %h",
          RamBase + 32'(index * 4), rdata, ramModel[index], error);
        errorCount++;
      end
      ramModel[index] = mergeLanes(ramModel[index], wdata, strb);
    end
  endtask

  task automatic refusedAccesses(input int count);
    logic [31:0] r;
    logic [31:0] addr;
    logic [3:0] strb;
    logic [31:0] rdata;
    logic error;
    for (int n = 0; n < count; n++) begin
      r = nextRandom();
      if (n % 2 == 0) begin
        addr = RomBase + (r % RomSize);
        strb = r[19:16] | 4'b0001;
      end else begin
        addr = r;
        while (isMapped(addr)) begin
          addr = nextRandom();
        end
        strb = r[3:0];
      end
      issueRequest(addr, nextRandom(), strb, 1'b0, rdata, error);
      checkCount++;
      if (error !== 1'b1 || rdata !== 32'h0) begin
        $display("Fail memError at %h: got %h expected 1, memRdata %h expected 0",
          addr, error, rdata);
        errorCount++;
      end
    end
  endtask

  task automatic checkTimeCount(input int count);
    logic [31:0] written;
    logic [31:0] first;
    logic [31:0] second;
    logic [31:0] upper;
    logic [31:0] rdata;
    logic error;
    int start;
    for (int n = 0; n < count; n++) begin
      written = nextRandom() & 32'h0FFF_FFFF;  // No carry into the high half
      start = cycleCount;
      issueRequest(TimerBase + 32'(TimeLowOffset), written, 4'b1111, 1'b0, rdata, error);
      issueRequest(TimerBase + 32'(TimeLowOffset), 32'h0, 4'b0000, 1'b0, first, error);
      upper = written + 32'((cycleCount - start) / TimerDivide + 1);
      checkCount++;
      if (first < written || first > upper) begin
        $display("Fail timeLow: got %h expected %h to %h", first, written, upper);
        errorCount++;
      end
      issueRequest(TimerBase + 32'(TimeLowOffset), 32'h0, 4'b0000, 1'b0, second, error);
      checkCount++;
      if (second < first) begin
        $display("Fail timeLow: second read %h below first %h", second, first);
        errorCount++;
      end
    end
  endtask

  task automatic checkInterrupt();
    logic [31:0] low;
    logic [31:0] high;
    logic [31:0] rdata;
    logic error;
    int waited;
    issueRequest(TimerBase + 32'(TimeLowOffset), 32'h0, 4'b0000, 1'b0, low, error);
    issueRequest(TimerBase + 32'(TimeHighOffset), 32'h0, 4'b0000, 1'b0, high, error);
    issueRequest(TimerBase + 32'(CompareHighOffset), high, 4'b1111, 1'b0, rdata, error);
    issueRequest(TimerBase + 32'(CompareLowOffset), low + 32'd16, 4'b1111, 1'b0, rdata, error);
    waited = 0;
    while (!timerIrq && waited < 200) begin
      @(negedge clock);
      waited++;
    end
    checkCount++;
    if (!timerIrq) begin
      $display("Timer interrupt did not rise within 200 cycles");
      errorCount++;
    end
    issueRequest(TimerBase + 32'(CompareLowOffset), '1, 4'b1111, 1'b0, rdata, error);
    issueRequest(TimerBase + 32'(CompareHighOffset), '1, 4'b1111, 1'b0, rdata, error);
    waited = 0;
    while (timerIrq && waited < 8) begin
      @(negedge clock);
      waited++;
    end
    checkCount++;
    if (timerIrq) begin
      $display("Timer interrupt stayed high after compare was set to all ones");
      errorCount++;
    end
  endtask

  // --------------------------------------------------------------------------
  // Sequence

  initial begin
    int errorsBefore;
    clock = 1'b0;
    reset = 1'b1;
    memIn = '0;
    repeat (10) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    checkCount++;
    if (memOut.memReady || memOut.memError || timerIrq) begin
      $display("memReady, memError or timerIrq high right after reset");
      errorCount++;
    end
    errorsBefore = errorCount;
    readRomWords(200);
    reportTest("ROM reads", errorsBefore);
    errorsBefore = errorCount;
    fillRam();
    accessRam(1000, 1'b1);
    reportTest("RAM accesses", errorsBefore);
    errorsBefore = errorCount;
    refusedAccesses(100);
    readRomWords(64);
    accessRam(64, 1'b0);
    reportTest("Error responses", errorsBefore);
    errorsBefore = errorCount;
    checkTimeCount(10);
    reportTest("Timer count", errorsBefore);
    errorsBefore = errorCount;
    checkInterrupt();
    reportTest("Timer interrupt", errorsBefore);
    $display("Checks %0d, errors %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

/* test/memorySystem_checker.sv */
`timescale 1ns/1ns

module memorySystem_checker import configure::*; (
  input logic clock,
  input logic reset,
  input memInType memIn,
  input memOutType memOut,
  input busStateType state,
  input logic romValid,
  input logic ramValid,
  input logic timerValid
);

  // --------------------------------------------------------------------------
  // Handshake

  assert property (@(posedge clock) disable iff (reset)
    memOut.memReady |-> $past(memIn.memValid, 2))
    else $error("memReady without a request two cycles earlier");

  assert property (@(posedge clock) disable iff (reset)
    memIn.memValid |-> ##2 memOut.memReady)
    else $error("Request not answered two cycles later");

  assert property (@(posedge clock) disable iff (reset)
    memIn.memValid |-> state == StateIdle)
    else $error("Request while the controller is busy");

  // A single target sees valid, one cycle after the request
  assert property (@(posedge clock) disable iff (reset)
    (romValid || ramValid || timerValid) |->
      $onehot0({romValid, ramValid, timerValid}) && $past(memIn.memValid))
    else $error("Target valid without a single request one cycle earlier");

  // Registers are cleared after the first reset edge
  assert property (@(posedge clock) reset |=> !memOut.memReady)
    else $error("memReady high during reset");

endmodule

bind busController memorySystem_checker memorySystem_checker_i (
  .clock(clock),
  .reset(reset),
  .memIn(memIn),
  .memOut(memOut),
  .state(state),
  .romValid(romIn.memValid),
  .ramValid(ramIn.memValid),
  .timerValid(timerIn.memValid)
);

/* verilog.f */
hw/configure.sv
hw/bootRom.sv
hw/dataRam.sv
hw/machineTimer.sv
hw/busController.sv
hw/memorySystem.sv
test/memorySystem_checker.sv
test/memorySystemTb.sv
